//--- hdl/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

`define CPU_XLEN     32
`define CPU_REGSEL_W 4
`define CPU_ALUSEL_W 3
`define CPU_JMPREL_W 8

// Instruction word fields
`define CPU_F_CLASS  31:28
`define CPU_F_RD     27:24
`define CPU_F_ALU    23:21
`define CPU_F_RS     20:17
`define CPU_F_IMMEN  16
`define CPU_F_IMM    15:0
`define CPU_F_RT     11:8
`define CPU_F_JMPREL 7:0
`define CPU_F_RREAD  1
`define CPU_F_CREAD  0

`define CPU_REG_ZERO 4'd0
`define CPU_REG_A    4'd1
`define CPU_REG_B    4'd2
`define CPU_REG_C    4'd3
`define CPU_REG_D    4'd4
`define CPU_REG_E    4'd5
`define CPU_REG_F    4'd6
`define CPU_REG_G    4'd7
`define CPU_REG_H    4'd8
`define CPU_REG_I    4'd9
`define CPU_REG_J    4'd10
`define CPU_REG_RA   4'd11
`define CPU_REG_SL   4'd12
`define CPU_REG_SH   4'd13
`define CPU_REG_N    4'd14
`define CPU_REG_PC   4'd15

`define CPU_PC_RESET 32'd0

`endif

//--- hdl/cpu_pkg.sv
package cpu_pkg;

    // Codes not listed here behave as NOP
    typedef enum logic [3:0] {
        CLS_NOP   = 4'h0,
        CLS_ALU   = 4'h1,
        CLS_STORE = 4'h2,
        CLS_JNZ   = 4'h3
    } inst_class_e;

    typedef enum logic [2:0] {
        ALU_ADD      = 3'd0,
        ALU_SUB      = 3'd1,
        ALU_OR       = 3'd2,
        ALU_AND      = 3'd3,
        ALU_XOR      = 3'd4,
        ALU_RESERVED = 3'd5,
        ALU_CLAMP    = 3'd6,
        ALU_MUL      = 3'd7
    } alu_op_e;

endpackage

//--- hdl/dcd_bus.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

interface dcd_bus;
    import cpu_pkg::*;

    inst_class_e               cls;
    alu_op_e                   alu_op;
    logic [`CPU_REGSEL_W-1:0]  rdsel;
    logic                      imm_en;
    logic [`CPU_XLEN-1:0]      imm;
    logic                      r_read_en;
    logic                      c_read_en;

    modport producer (
        output cls,
        output alu_op,
        output rdsel,
        output imm_en,
        output imm,
        output r_read_en,
        output c_read_en
    );

    modport consumer (
        input cls,
        input alu_op,
        input rdsel,
        input imm_en,
        input imm,
        input r_read_en,
        input c_read_en
    );

endinterface

//--- hdl/cpu_seq.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_seq (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      is_jnz_i,
    input  logic [`CPU_XLEN-1:0]      inst_pc_i,
    input  logic [`CPU_JMPREL_W-1:0]  jmprel_i,
    input  logic                      regn_is_zero_i,
    output logic [`CPU_XLEN-1:0]      p_addr_o,
    output logic [`CPU_XLEN-1:0]      fetch_pc_o,
    output logic                      squash_o
);

    logic [`CPU_XLEN-1:0] pc_q;
    logic [`CPU_XLEN-1:0] jmp_off;
    logic [`CPU_XLEN-1:0] jmp_target;
    logic                 taken;

    // JNZ is resolved while it sits in the decode register
    assign taken = is_jnz_i && !regn_is_zero_i;

    always_comb begin
        jmp_off    = $signed(jmprel_i);
        jmp_target = inst_pc_i + jmp_off;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= `CPU_PC_RESET;
        end else if (taken) begin
            pc_q <= jmp_target;
        end else begin
            pc_q <= pc_q + 1'b1;
        end
    end

    assign p_addr_o   = pc_q;
    assign fetch_pc_o = pc_q;

    // Kills the slot fetched right after the JNZ
    assign squash_o = taken;

endmodule

//--- hdl/cpu_decode.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_decode (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`CPU_XLEN-1:0]      inst_i,
    input  logic [`CPU_XLEN-1:0]      fetch_pc_i,
    input  logic                      squash_i,
    output logic [`CPU_REGSEL_W-1:0]  rssel_o,
    output logic [`CPU_REGSEL_W-1:0]  rtsel_o,
    output logic                      is_jnz_o,
    output logic [`CPU_XLEN-1:0]      inst_pc_o,
    output logic [`CPU_JMPREL_W-1:0]  jmprel_o,
    dcd_bus.producer                  dcd
);
    import cpu_pkg::*;

    logic [`CPU_XLEN-1:0]      f_imm;
    logic                      f_imm_en;
    logic                      f_r_read_en;
    logic                      f_c_read_en;

    // Decode register
    inst_class_e               d_cls;
    alu_op_e                   d_alu_op;
    logic [`CPU_REGSEL_W-1:0]  d_rdsel;
    logic [`CPU_REGSEL_W-1:0]  d_rssel;
    logic [`CPU_REGSEL_W-1:0]  d_rtsel;
    logic                      d_imm_en;
    logic [`CPU_XLEN-1:0]      d_imm;
    logic [`CPU_JMPREL_W-1:0]  d_jmprel;
    logic                      d_r_read_en;
    logic                      d_c_read_en;
    logic [`CPU_XLEN-1:0]      d_pc;

    always_comb begin
        f_imm_en    = inst_i[`CPU_F_IMMEN];
        f_imm       = $signed(inst_i[`CPU_F_IMM]);
        // Immediate replaces any bus load
        f_r_read_en = inst_i[`CPU_F_RREAD] && !f_imm_en;
        f_c_read_en = inst_i[`CPU_F_CREAD] && !f_imm_en;
    end

    always_ff @(posedge clk) begin
        if (rst || squash_i) begin
            d_cls <= CLS_NOP;
        end else begin
            d_cls <= inst_class_e'(inst_i[`CPU_F_CLASS]);
        end
    end

    always_ff @(posedge clk) begin
        d_alu_op    <= alu_op_e'(inst_i[`CPU_F_ALU]);
        d_rdsel     <= inst_i[`CPU_F_RD];
        d_rssel     <= inst_i[`CPU_F_RS];
        d_rtsel     <= inst_i[`CPU_F_RT];
        d_imm_en    <= f_imm_en;
        d_imm       <= f_imm;
        d_jmprel    <= inst_i[`CPU_F_JMPREL];
        d_r_read_en <= f_r_read_en;
        d_c_read_en <= f_c_read_en;
        d_pc        <= fetch_pc_i;
    end

    // Operand stage aligned with the registered regfile reads
    always_ff @(posedge clk) begin
        if (rst) begin
            dcd.cls <= CLS_NOP;
        end else begin
            dcd.cls <= d_cls;
        end
    end

    always_ff @(posedge clk) begin
        dcd.alu_op    <= d_alu_op;
        dcd.rdsel     <= d_rdsel;
        dcd.imm_en    <= d_imm_en;
        dcd.imm       <= d_imm;
        dcd.r_read_en <= d_r_read_en;
        dcd.c_read_en <= d_c_read_en;
    end

    assign rssel_o   = d_rssel;
    assign rtsel_o   = d_rtsel;
    assign is_jnz_o  = (d_cls == CLS_JNZ);
    assign inst_pc_o = d_pc;
    assign jmprel_o  = d_jmprel;

endmodule

//--- hdl/cpu_regfile.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_regfile (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`CPU_REGSEL_W-1:0]  rssel_i,
    input  logic [`CPU_REGSEL_W-1:0]  rtsel_i,
    input  logic [`CPU_REGSEL_W-1:0]  wb_sel_i,
    input  logic [`CPU_XLEN-1:0]      wb_val_i,
    output logic [`CPU_XLEN-1:0]      rs_val_o,
    output logic [`CPU_XLEN-1:0]      rt_val_o,
    output logic                      regn_is_zero_o
);

    localparam int NUM_REGS = 13;

    logic [`CPU_XLEN-1:0] regs [NUM_REGS];
    logic [`CPU_XLEN-1:0] rs_q;
    logic [`CPU_XLEN-1:0] rt_q;

    // zero, ra and pc have no storage
    function automatic logic has_storage(input logic [`CPU_REGSEL_W-1:0] sel);
        return (sel != `CPU_REG_ZERO) && (sel != `CPU_REG_RA) && (sel != `CPU_REG_PC);
    endfunction

    // Storage slot, skipping the hole at ra
    function automatic logic [`CPU_REGSEL_W-1:0] slot(input logic [`CPU_REGSEL_W-1:0] sel);
        if (sel < `CPU_REG_RA) begin
            return sel - 4'd1;
        end
        return sel - 4'd2;
    endfunction

    function automatic logic [`CPU_XLEN-1:0] read_reg(input logic [`CPU_REGSEL_W-1:0] sel);
        if (!has_storage(sel)) begin
            return '0;
        end
        return regs[slot(sel)];
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (has_storage(wb_sel_i)) begin
            regs[slot(wb_sel_i)] <= wb_val_i;
        end
    end

    always_ff @(posedge clk) begin
        rs_q <= read_reg(rssel_i);
        rt_q <= read_reg(rtsel_i);
    end

    assign rs_val_o = rs_q;
    assign rt_val_o = rt_q;

    // Read straight from n for the JNZ test in decode
    assign regn_is_zero_o = (regs[slot(`CPU_REG_N)] == '0);

endmodule

//--- hdl/cpu_mem.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_mem (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`CPU_XLEN-1:0]      rs_val_i,
    input  logic [`CPU_XLEN-1:0]      rt_val_i,
    input  logic [`CPU_XLEN-1:0]      r_data_i,
    input  logic [`CPU_XLEN-1:0]      c_data_i,
    dcd_bus.consumer                  dcd,
    output logic [`CPU_XLEN-1:0]      r_addr_o,
    output logic [`CPU_XLEN-1:0]      r_data_o,
    output logic                      r_we_o,
    output logic [`CPU_XLEN-1:0]      c_addr_o,
    output logic [`CPU_XLEN-1:0]      s_val_o,
    output logic [`CPU_XLEN-1:0]      t_val_o,
    output cpu_pkg::alu_op_e          alu_op_o,
    output logic [`CPU_REGSEL_W-1:0]  rdsel_o,
    output logic                      wr_en_o
);
    import cpu_pkg::*;

    logic [`CPU_XLEN-1:0] s_sel;
    logic [`CPU_XLEN-1:0] t_sel;

    // Register values double as bus addresses
    assign r_addr_o = rs_val_i;
    assign c_addr_o = rt_val_i;

    always_comb begin
        s_sel = dcd.r_read_en ? r_data_i : rs_val_i;
        if (dcd.imm_en) begin
            t_sel = dcd.imm;
        end else if (dcd.c_read_en) begin
            t_sel = c_data_i;
        end else begin
            t_sel = rt_val_i;
        end
    end

    // Store goes out in this cycle
    assign r_we_o   = (dcd.cls == CLS_STORE);
    assign r_data_o = t_sel;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_en_o <= 1'b0;
        end else begin
            wr_en_o <= (dcd.cls == CLS_ALU);
        end
    end

    always_ff @(posedge clk) begin
        s_val_o  <= s_sel;
        t_val_o  <= t_sel;
        alu_op_o <= dcd.alu_op;
        rdsel_o  <= dcd.rdsel;
    end

endmodule

//--- hdl/cpu_ex.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_ex (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`CPU_XLEN-1:0]      s_val_i,
    input  logic [`CPU_XLEN-1:0]      t_val_i,
    input  cpu_pkg::alu_op_e          alu_op_i,
    input  logic [`CPU_REGSEL_W-1:0]  rdsel_i,
    input  logic                      wr_en_i,
    output logic [`CPU_REGSEL_W-1:0]  wb_sel_o,
    output logic [`CPU_XLEN-1:0]      wb_val_o
);
    import cpu_pkg::*;

    logic [`CPU_XLEN-1:0]   alu_res;
    logic [`CPU_XLEN-1:0]   clamp_hi;
    logic [2*`CPU_XLEN-1:0] prod;

    // Upper bound first, then floor at zero
    always_comb begin
        if ($signed(s_val_i) > $signed(t_val_i)) begin
            clamp_hi = t_val_i;
        end else begin
            clamp_hi = s_val_i;
        end
    end

    assign prod = s_val_i * t_val_i;

    always_comb begin
        case (alu_op_i)
            ALU_ADD: begin
                alu_res = s_val_i + t_val_i;
            end
            ALU_SUB: begin
                alu_res = s_val_i - t_val_i;
            end
            ALU_OR: begin
                alu_res = s_val_i | t_val_i;
            end
            ALU_AND: begin
                alu_res = s_val_i & t_val_i;
            end
            ALU_XOR: begin
                alu_res = s_val_i ^ t_val_i;
            end
            ALU_CLAMP: begin
                alu_res = $signed(clamp_hi) < 0 ? '0 : clamp_hi;
            end
            ALU_MUL: begin
                // Low word only
                alu_res = prod[`CPU_XLEN-1:0];
            end
            default: begin
                alu_res = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_sel_o <= `CPU_REG_ZERO;
        end else begin
            wb_sel_o <= wr_en_i ? rdsel_i : `CPU_REG_ZERO;
        end
    end

    always_ff @(posedge clk) begin
        wb_val_o <= alu_res;
    end

endmodule

//--- hdl/cpu_core.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_core (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`CPU_XLEN-1:0]  p_data_i,
    input  logic [`CPU_XLEN-1:0]  r_data_i,
    input  logic [`CPU_XLEN-1:0]  c_data_i,
    output logic [`CPU_XLEN-1:0]  p_addr_o,
    output logic [`CPU_XLEN-1:0]  r_addr_o,
    output logic [`CPU_XLEN-1:0]  r_data_o,
    output logic                  r_we_o,
    output logic [`CPU_XLEN-1:0]  c_addr_o
);
    import cpu_pkg::*;

    logic [`CPU_XLEN-1:0]      fetch_pc;
    logic                      squash;
    logic [`CPU_REGSEL_W-1:0]  rssel;
    logic [`CPU_REGSEL_W-1:0]  rtsel;
    logic                      is_jnz;
    logic [`CPU_XLEN-1:0]      inst_pc;
    logic [`CPU_JMPREL_W-1:0]  jmprel;
    logic [`CPU_XLEN-1:0]      rs_val;
    logic [`CPU_XLEN-1:0]      rt_val;
    logic                      regn_is_zero;
    logic [`CPU_XLEN-1:0]      s_val;
    logic [`CPU_XLEN-1:0]      t_val;
    alu_op_e                   ex_alu_op;
    logic [`CPU_REGSEL_W-1:0]  ex_rdsel;
    logic                      ex_wr_en;
    logic [`CPU_REGSEL_W-1:0]  wb_sel;
    logic [`CPU_XLEN-1:0]      wb_val;

    // Decode to memory stage
    dcd_bus dcd_if ();

    cpu_seq u_seq (
        .clk            (clk),
        .rst            (rst),
        .is_jnz_i       (is_jnz),
        .inst_pc_i      (inst_pc),
        .jmprel_i       (jmprel),
        .regn_is_zero_i (regn_is_zero),
        .p_addr_o       (p_addr_o),
        .fetch_pc_o     (fetch_pc),
        .squash_o       (squash)
    );

    cpu_decode u_decode (
        .clk        (clk),
        .rst        (rst),
        .inst_i     (p_data_i),
        .fetch_pc_i (fetch_pc),
        .squash_i   (squash),
        .rssel_o    (rssel),
        .rtsel_o    (rtsel),
        .is_jnz_o   (is_jnz),
        .inst_pc_o  (inst_pc),
        .jmprel_o   (jmprel),
        .dcd        (dcd_if.producer)
    );

    cpu_regfile u_regfile (
        .clk            (clk),
        .rst            (rst),
        .rssel_i        (rssel),
        .rtsel_i        (rtsel),
        .wb_sel_i       (wb_sel),
        .wb_val_i       (wb_val),
        .rs_val_o       (rs_val),
        .rt_val_o       (rt_val),
        .regn_is_zero_o (regn_is_zero)
    );

    cpu_mem u_mem (
        .clk      (clk),
        .rst      (rst),
        .rs_val_i (rs_val),
        .rt_val_i (rt_val),
        .r_data_i (r_data_i),
        .c_data_i (c_data_i),
        .dcd      (dcd_if.consumer),
        .r_addr_o (r_addr_o),
        .r_data_o (r_data_o),
        .r_we_o   (r_we_o),
        .c_addr_o (c_addr_o),
        .s_val_o  (s_val),
        .t_val_o  (t_val),
        .alu_op_o (ex_alu_op),
        .rdsel_o  (ex_rdsel),
        .wr_en_o  (ex_wr_en)
    );

    cpu_ex u_ex (
        .clk      (clk),
        .rst      (rst),
        .s_val_i  (s_val),
        .t_val_i  (t_val),
        .alu_op_i (ex_alu_op),
        .rdsel_i  (ex_rdsel),
        .wr_en_i  (ex_wr_en),
        .wb_sel_o (wb_sel),
        .wb_val_o (wb_val)
    );

endmodule

//--- test/tb_cpu_core.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module tb_cpu_core;
    import cpu_pkg::*;

    localparam int NUM_ROWS  = 32;
    localparam int NUM_FIXED = 16;

    logic        clk;
    logic        rst;
    logic [31:0] p_addr;
    logic [31:0] p_data;
    logic [31:0] r_addr;
    logic [31:0] r_data;
    logic [31:0] r_wdata;
    logic        r_we;
    logic [31:0] c_addr;
    logic [31:0] c_data;

    logic [31:0] p_mem [1024];
    logic [31:0] r_mem [512];
    logic [31:0] c_mem [256];

    // Operation table
    alu_op_e     tab_op  [NUM_ROWS];
    logic [31:0] tab_s   [NUM_ROWS];
    logic [31:0] tab_t   [NUM_ROWS];
    logic [31:0] tab_exp [NUM_ROWS];
    int          n_rows;

    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    int          n_exp;
    int          plen;
    int          loop_start;
    int          first_store;
    int          cyc;
    int          store_cnt;
    int          timeout_cycles;

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // Bus models answer in the same cycle
    assign p_data = p_mem[p_addr[9:0]];
    assign r_data = r_mem[r_addr[8:0]];
    assign c_data = c_mem[c_addr[7:0]];

    cpu_core i_dut (
        .clk      (clk),
        .rst      (rst),
        .p_data_i (p_data),
        .r_data_i (r_data),
        .c_data_i (c_data),
        .p_addr_o (p_addr),
        .r_addr_o (r_addr),
        .r_data_o (r_wdata),
        .r_we_o   (r_we),
        .c_addr_o (c_addr)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] v;
        v = x ^ (x << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic logic [31:0] alu_ref(input alu_op_e op, input logic [31:0] s,
                                           input logic [31:0] t);
        case (op)
            ALU_ADD:   return s + t;
            ALU_SUB:   return s - t;
            ALU_OR:    return s | t;
            ALU_AND:   return s & t;
            ALU_XOR:   return s ^ t;
            ALU_MUL:   return s * t;
            ALU_CLAMP: begin
                // Empty range when T is negative
                if ($signed(s) < 0 || $signed(t) < 0) begin
                    return 32'd0;
                end
                return ($signed(s) > $signed(t)) ? t : s;
            end
            default:   return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] enc_base(input inst_class_e cls, input alu_op_e op,
                                             input logic [3:0] rd, input logic [3:0] rs);
        logic [31:0] w;
        w = '0;
        w[`CPU_F_CLASS] = cls;
        w[`CPU_F_RD]    = rd;
        w[`CPU_F_ALU]   = op;
        w[`CPU_F_RS]    = rs;
        return w;
    endfunction

    function automatic logic [31:0] enc_reg(input inst_class_e cls, input alu_op_e op,
                                            input logic [3:0] rd, input logic [3:0] rs,
                                            input logic [3:0] rt, input logic rread,
                                            input logic cread);
        logic [31:0] w;
        w = enc_base(cls, op, rd, rs);
        w[`CPU_F_RT]    = rt;
        w[`CPU_F_RREAD] = rread;
        w[`CPU_F_CREAD] = cread;
        return w;
    endfunction

    function automatic logic [31:0] enc_imm(input inst_class_e cls, input alu_op_e op,
                                            input logic [3:0] rd, input logic [3:0] rs,
                                            input logic [15:0] imm);
        logic [31:0] w;
        w = enc_base(cls, op, rd, rs);
        w[`CPU_F_IMMEN] = 1'b1;
        w[`CPU_F_IMM]   = imm;
        return w;
    endfunction

    task automatic emit(input logic [31:0] w);
        p_mem[plen] = w;
        plen++;
    endtask

    // Three NOP slots keep the result clear of the next reader
    task automatic emit_write(input logic [31:0] w);
        emit(w);
        repeat (3) emit(32'd0);
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] %0t ns: %s: got %h, expected %h",
                               $time, what, got, exp));
        end
    endtask

    task automatic add_row(input alu_op_e op, input logic [31:0] s, input logic [31:0] t);
        tab_op[n_rows]  = op;
        tab_s[n_rows]   = s;
        tab_t[n_rows]   = t;
        tab_exp[n_rows] = alu_ref(op, s, t);
        n_rows++;
    endtask

    task automatic build_table();
        logic [31:0] rnd;
        logic [31:0] s;
        add_row(ALU_ADD, 32'h7fff_ffff, 32'h0000_0001);
        add_row(ALU_ADD, 32'hffff_ffff, 32'h0000_0001);
        add_row(ALU_SUB, 32'h0000_0000, 32'h0000_0001);
        add_row(ALU_SUB, 32'h8000_0000, 32'h0000_0001);
        add_row(ALU_OR, 32'hf0f0_0f0f, 32'h0ff0_1234);
        add_row(ALU_AND, 32'hf0f0_0f0f, 32'h0ff0_ffff);
        add_row(ALU_XOR, 32'hdead_beef, 32'hffff_0000);
        add_row(ALU_RESERVED, 32'h1234_5678, 32'h9abc_def0);
        add_row(ALU_CLAMP, 32'd5, 32'd10);
        add_row(ALU_CLAMP, 32'd20, 32'd10);
        add_row(ALU_CLAMP, 32'hffff_fff9, 32'd10);
        add_row(ALU_CLAMP, 32'd5, 32'hffff_fffd);
        add_row(ALU_CLAMP, 32'h7fff_ffff, 32'h7fff_ffff);
        add_row(ALU_MUL, 32'h0001_0000, 32'h0001_0000);
        add_row(ALU_MUL, 32'hffff_ffff, 32'd3);
        add_row(ALU_MUL, 32'd12345, 32'd6789);
        rnd = 32'h7817fa92;
        for (int i = NUM_FIXED; i < NUM_ROWS; i++) begin
            rnd = xorshift(rnd);
            s   = xorshift(rnd);
            add_row(alu_op_e'(rnd[2:0]), s, xorshift(s));
            rnd = xorshift(s);
        end
    endtask

    task automatic build_program();
        for (int i = 0; i < n_rows; i++) begin
            r_mem[i] = tab_s[i];
            c_mem[i] = tab_t[i];
            emit_write(enc_imm(CLS_ALU, ALU_ADD, `CPU_REG_A, `CPU_REG_ZERO, 16'(i)));
            emit_write(enc_imm(CLS_ALU, ALU_ADD, `CPU_REG_C, `CPU_REG_ZERO, 16'(256 + i)));
            emit_write(enc_reg(CLS_ALU, tab_op[i], `CPU_REG_D, `CPU_REG_A, `CPU_REG_A,
                               1'b1, 1'b1));
            if (first_store < 0) begin
                first_store = plen;
            end
            emit(enc_reg(CLS_STORE, ALU_ADD, `CPU_REG_ZERO, `CPU_REG_C, `CPU_REG_D, 1'b0, 1'b0));
            expect_store(32'(256 + i), tab_exp[i]);
        end
        // Immediate 0x7fff also carries both read flags
        emit_write(enc_imm(CLS_ALU, ALU_ADD, `CPU_REG_C, `CPU_REG_ZERO, 16'd300));
        emit_write(enc_imm(CLS_ALU, ALU_ADD, `CPU_REG_E, `CPU_REG_ZERO, 16'h7fff));
        emit_write(enc_imm(CLS_ALU, ALU_ADD, `CPU_REG_F, `CPU_REG_ZERO, 16'h8000));
        emit(enc_reg(CLS_STORE, ALU_ADD, `CPU_REG_ZERO, `CPU_REG_C, `CPU_REG_E, 1'b0, 1'b0));
        expect_store(32'd300, 32'h0000_7fff);
        emit(enc_reg(CLS_STORE, ALU_ADD, `CPU_REG_ZERO, `CPU_REG_C, `CPU_REG_F, 1'b0, 1'b0));
        expect_store(32'd300, 32'hffff_8000);
        // Registers without storage, j sits next to the ra hole
        emit_write(enc_imm(CLS_ALU, ALU_ADD, `CPU_REG_J, `CPU_REG_ZERO, 16'h1111));
        emit_write(enc_imm(CLS_ALU, ALU_ADD, `CPU_REG_ZERO, `CPU_REG_ZERO, 16'h1234));
        emit_write(enc_imm(CLS_ALU, ALU_ADD, `CPU_REG_RA, `CPU_REG_ZERO, 16'h1234));
        emit_write(enc_imm(CLS_ALU, ALU_ADD, `CPU_REG_PC, `CPU_REG_ZERO, 16'h1234));
        emit(enc_reg(CLS_STORE, ALU_ADD, `CPU_REG_ZERO, `CPU_REG_C, `CPU_REG_ZERO, 1'b0, 1'b0));
        emit(enc_reg(CLS_STORE, ALU_ADD, `CPU_REG_ZERO, `CPU_REG_C, `CPU_REG_RA, 1'b0, 1'b0));
        emit(enc_reg(CLS_STORE, ALU_ADD, `CPU_REG_ZERO, `CPU_REG_C, `CPU_REG_PC, 1'b0, 1'b0));
        emit(enc_reg(CLS_STORE, ALU_ADD, `CPU_REG_ZERO, `CPU_REG_C, `CPU_REG_J, 1'b0, 1'b0));
        repeat (3) expect_store(32'd300, 32'd0);
        expect_store(32'd300, 32'h0000_1111);
        // Countdown loop on n
        emit_write(enc_imm(CLS_ALU, ALU_ADD, `CPU_REG_E, `CPU_REG_ZERO, 16'd400));
        emit_write(enc_imm(CLS_ALU, ALU_ADD, `CPU_REG_N, `CPU_REG_ZERO, 16'd3));
        loop_start = plen;
        emit(enc_reg(CLS_STORE, ALU_ADD, `CPU_REG_ZERO, `CPU_REG_E, `CPU_REG_N, 1'b0, 1'b0));
        emit_write(enc_imm(CLS_ALU, ALU_SUB, `CPU_REG_N, `CPU_REG_N, 16'd1));
        emit(enc_imm(CLS_JNZ, ALU_ADD, `CPU_REG_ZERO, `CPU_REG_ZERO, {8'd0, 8'(loop_start - plen)}));
        emit(enc_imm(CLS_STORE, ALU_ADD, `CPU_REG_ZERO, `CPU_REG_E, 16'h5a5a));
        expect_store(32'd400, 32'd3);
        expect_store(32'd400, 32'd2);
        expect_store(32'd400, 32'd1);
        expect_store(32'd400, 32'h0000_5a5a);
    endtask

    // Sample mid-cycle, away from the clock edge
    always @(negedge clk) begin
        if (rst) begin
            check({31'd0, r_we}, 32'd0, "r_we_o during reset");
        end else if (cyc >= timeout_cycles) begin
            fail_run("Timeout: the expected store count was not reached");
        end else begin
            if (cyc < loop_start) begin
                check(p_addr, 32'(cyc), "fetch address");
            end
            if (cyc < first_store + 2) begin
                check({31'd0, r_we}, 32'd0, "r_we_o before first store");
            end
            if (r_we && store_cnt >= n_exp) begin
                fail_run("An unexpected store appeared on bus R");
            end else if (r_we) begin
                check(r_addr, exp_addr[store_cnt], $sformatf("store %0d address", store_cnt));
                check(r_wdata, exp_data[store_cnt], $sformatf("store %0d data", store_cnt));
                store_cnt++;
            end
            cyc++;
        end
    end

    initial begin
        rst         = 1'b1;
        cyc         = 0;
        store_cnt   = 0;
        plen        = 0;
        n_rows      = 0;
        first_store = -1;
        for (int a = 0; a < 1024; a++) begin
            p_mem[a] = 32'd0;
        end
        for (int a = 0; a < 512; a++) begin
            r_mem[a] = 32'ha500_0000 | 32'(a);
        end
        for (int a = 0; a < 256; a++) begin
            c_mem[a] = 32'h3c00_0000 | 32'(a);
        end
        build_table();
        build_program();
        n_exp          = exp_addr.size();
        timeout_cycles = plen * 2 + 100;
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;
        wait (store_cnt == n_exp);
        // A few more cycles to catch stray stores
        repeat (8) @(posedge clk);
        $display("Done: no errors");
        $finish;
    end

endmodule

//--- all.f
+incdir+hdl
hdl/cpu_pkg.sv
hdl/dcd_bus.sv
hdl/cpu_seq.sv
hdl/cpu_decode.sv
hdl/cpu_regfile.sv
hdl/cpu_mem.sv
hdl/cpu_ex.sv
hdl/cpu_core.sv
test/tb_cpu_core.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench; exit status is nonzero on failure
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_cpu_core -f all.f &&
./obj_dir/Vtb_cpu_core || exit 1
